//--- design/upload_pkg.sv
`default_nettype none

package upload_pkg;

   typedef logic [27:0] ddr_addr_t;
   typedef logic [26:0] ram_addr_t;
   typedef logic [24:0] data_size_t;

   localparam int HDR_BYTES = 16;
   localparam int KBD_SKIP  = 512;                  // Keyboard layout body

   // Magic sits in header bytes 0 to 2
   localparam int OFS_TYPE    = 3;                  // Type in [7:4] and slot in [3:0]
   localparam int OFS_DATA_ID = 4;
   localparam int OFS_SIZE_HI = 5;
   localparam int OFS_SIZE_LO = 6;
   localparam int OFS_DEVICE  = 7;
   localparam int OFS_MAPPER  = 8;
   localparam int OFS_MODE    = 9;
   localparam int OFS_PARAM   = 10;

   typedef enum logic [3:0] {CONFIG_NONE, CONFIG_SLOT_A, CONFIG_SLOT_B, CONFIG_SLOT_INTERNAL,
                             CONFIG_KBD_LAYOUT, CONFIG_CONFIG} config_typ_t;

   typedef enum logic [7:0] {ROM_NONE, ROM_ROM, ROM_RAM, ROM_FDC, ROM_FMPAC} data_id_t;

   typedef enum logic [7:0] {MAPPER_UNUSED, MAPPER_NONE, MAPPER_ASCII8, MAPPER_ASCII16,
                             MAPPER_KONAMI, MAPPER_KONAMI_SCC, MAPPER_RAM} mapper_t;

   typedef enum logic [7:0] {DEVICE_NONE, DEVICE_FDC, DEVICE_OPL3} device_t;

   typedef enum logic {PATTERN_COPY, PATTERN_RAM_INIT} pattern_t;

   typedef struct packed {
      mapper_t    mapper;
      device_t    device;
      logic [3:0] ref_ram;
      logic [1:0] offset_ram;
   } slot_entry_t;

   typedef struct packed {
      ram_addr_t   addr;
      logic [15:0] size;                            // In blocks
      logic        ro;
   } lookup_ram_t;

   typedef enum logic [2:0] {IDLE, CLEAN, READ_HDR, CHECK, FILL, STORE} seq_state_t;

endpackage

`default_nettype wire

//--- design/upload_if.sv
`timescale 1ns/1ps
`default_nettype none

interface record_if import upload_pkg::*; ();
   logic        magic_ok;
   config_typ_t rec_type;
   logic [3:0]  slot_subslot;
   data_id_t    data_id;
   logic [10:0] size_blocks;
   device_t     device;
   mapper_t     mapper;
   logic [7:0]  mode;
   logic [7:0]  param;

   modport parser (output magic_ok, rec_type, slot_subslot, data_id, size_blocks,
                   device, mapper, mode, param);
   modport user (input magic_ok, rec_type, slot_subslot, data_id, size_blocks,
                 device, mapper, mode, param);
endinterface

interface fetch_if ();
   logic       start;
   logic       done;
   logic       byte_req;
   logic       byte_ok;
   logic [7:0] byte_data;
   logic       busy;

   modport sequencer (output start, byte_ok, byte_data, input done, byte_req, busy);
   modport loader (input start, byte_ok, byte_data, output done, byte_req, busy);
endinterface

`default_nettype wire

//--- design/upload_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module upload_sequencer import upload_pkg::*; #(
   parameter int BLOCK_SHIFT = 14
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        ioctl_download,
   input  logic [15:0] ioctl_index,
   input  logic [26:0] ioctl_addr,
   input  logic [7:0]  ddr3_dout,
   input  logic        ddr3_ready,
   output ddr_addr_t   ddr3_addr,
   output logic        ddr3_rd,
   output logic        ddr3_request,
   output logic        reset_rq,
   record_if.user      rec,
   fetch_if.sequencer  fetch,
   output logic        hdr_byte_ok,
   output logic [7:0]  hdr_byte,
   output logic        clean_wr,
   output logic [5:0]  clean_idx,
   output logic        store,
   output logic [3:0]  ref_ram
);

   seq_state_t state;
   ddr_addr_t  cfg_size;
   ddr_addr_t  body_end;                          // Next header after a copy body
   ddr_addr_t  body_len;
   logic       dl_last;
   logic       dl_end;
   logic       go;                                // DDR3 port free for a step
   logic [4:0] hdr_cnt;
   logic       loaded;
   logic       req_pend;
   logic       rd_wait;
   logic       fill_done;

   assign dl_end   = dl_last & ~ioctl_download & (ioctl_index == 16'd1);
   assign go       = ddr3_ready & ~ddr3_rd;
   assign body_len = (rec.data_id == ROM_RAM) ? '0 : ddr_addr_t'(rec.size_blocks) << BLOCK_SHIFT;

   assign reset_rq        = (state != IDLE);
   assign ddr3_request    = (state != IDLE);
   assign hdr_byte_ok     = go & (state == READ_HDR) & (hdr_cnt != 5'd0);
   assign hdr_byte        = ddr3_dout;
   assign clean_wr        = go & (state == CLEAN);
   assign store           = go & (state == STORE);
   assign fetch.byte_ok   = go & (state == FILL) & rd_wait;
   assign fetch.byte_data = ddr3_dout;

   always_ff @(posedge clk) begin
      if (dl_end) cfg_size <= ddr_addr_t'(ioctl_addr);
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= IDLE;
         dl_last     <= 1'b0;
         ddr3_rd     <= 1'b0;
         ddr3_addr   <= '0;
         hdr_cnt     <= 5'd0;
         clean_idx   <= 6'd0;
         ref_ram     <= 4'd0;
         loaded      <= 1'b0;
         req_pend    <= 1'b0;
         rd_wait     <= 1'b0;
         fill_done   <= 1'b0;
         fetch.start <= 1'b0;
      end else begin
         dl_last     <= ioctl_download;
         fetch.start <= 1'b0;
         if (fetch.byte_req) req_pend <= 1'b1;
         if (fetch.done) fill_done <= 1'b1;
         if (ddr3_ready && ddr3_rd) begin
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 1'b1;
         end
         if (dl_end) begin
            state     <= CLEAN;
            ddr3_rd   <= 1'b0;
            ddr3_addr <= '0;
            hdr_cnt   <= 5'd0;
            clean_idx <= 6'd0;
            ref_ram   <= 4'd0;
            loaded    <= 1'b0;
         end else if (go) begin
            case (state)
               CLEAN: begin
                  clean_idx <= clean_idx + 6'd1;
                  if (clean_idx == 6'd63) state <= READ_HDR;
               end
               READ_HDR: begin
                  if (hdr_cnt == 5'd0 && ddr3_addr >= cfg_size) begin
                     state <= IDLE;                  // Image exhausted
                  end else if (hdr_cnt == 5'(HDR_BYTES)) begin
                     hdr_cnt <= 5'd0;
                     state   <= CHECK;
                  end else begin
                     ddr3_rd <= 1'b1;
                     hdr_cnt <= hdr_cnt + 5'd1;
                  end
               end
               CHECK: begin
                  state <= READ_HDR;
                  if (!rec.magic_ok) begin
                     state <= IDLE;
                  end else if (rec.rec_type == CONFIG_KBD_LAYOUT) begin
                     ddr3_addr <= ddr3_addr + ddr_addr_t'(KBD_SKIP);
                  end else if (rec.rec_type == CONFIG_SLOT_INTERNAL) begin
                     state <= STORE;
                     if (rec.data_id != ROM_NONE) begin
                        state       <= FILL;
                        fetch.start <= 1'b1;
                        loaded      <= 1'b1;
                        fill_done   <= 1'b0;
                        body_end    <= ddr3_addr + body_len;
                     end
                  end
               end
               FILL: begin
                  if (rd_wait) begin
                     rd_wait <= 1'b0;                // byte_ok goes out now
                  end else if (req_pend) begin
                     ddr3_rd  <= 1'b1;
                     rd_wait  <= 1'b1;
                     req_pend <= 1'b0;
                  end else if (fill_done) begin
                     fill_done <= 1'b0;
                     ddr3_addr <= body_end;
                     state     <= STORE;
                  end
               end
               STORE: begin
                  ref_ram <= ref_ram + {3'd0, loaded};
                  loaded  <= 1'b0;
                  state   <= READ_HDR;
               end
               default: ;
            endcase
         end
      end
   end

   a_req_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
      fetch.byte_req |-> fetch.busy && state == FILL);

endmodule

`default_nettype wire

//--- design/config_parser.sv
`timescale 1ns/1ps
`default_nettype none

module config_parser import upload_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       hdr_byte_ok,
   input  logic [7:0] hdr_byte,
   record_if.parser   rec
);

   logic [3:0] idx;
   logic [7:0] hdr [HDR_BYTES];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         idx <= 4'd0;
      end else if (hdr_byte_ok) begin
         if (idx == 4'(HDR_BYTES - 1)) begin
            idx <= 4'd0;                            // Header complete
         end else begin
            idx <= idx + 4'd1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (hdr_byte_ok) hdr[idx] <= hdr_byte;
   end

   assign rec.magic_ok     = ({hdr[0], hdr[1], hdr[2]} == "MSX");
   assign rec.rec_type     = config_typ_t'(hdr[OFS_TYPE][7:4]);
   assign rec.slot_subslot = hdr[OFS_TYPE][3:0];
   assign rec.data_id      = data_id_t'(hdr[OFS_DATA_ID]);
   assign rec.size_blocks  = {hdr[OFS_SIZE_HI][2:0], hdr[OFS_SIZE_LO]};
   assign rec.device       = device_t'(hdr[OFS_DEVICE]);
   assign rec.mapper       = mapper_t'(hdr[OFS_MAPPER]);
   assign rec.mode         = hdr[OFS_MODE];
   assign rec.param        = hdr[OFS_PARAM];

   // Sequencer must sit in CHECK for at least a cycle after the last byte
   a_hdr_gap: assert property (@(posedge clk) disable iff (!rst_n)
      hdr_byte_ok && idx == 4'(HDR_BYTES - 1) |=> !hdr_byte_ok);

endmodule

`default_nettype wire

//--- design/ram_loader.sv
`timescale 1ns/1ps
`default_nettype none

module ram_loader import upload_pkg::*; #(
   parameter int BLOCK_SHIFT = 14
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        sdram_ready,
   output ram_addr_t   ram_addr,
   output logic [7:0]  ram_din,
   output logic        ram_ce,
   output lookup_ram_t lookup_ram [16],
   record_if.user      rec,
   fetch_if.loader     fetch,
   input  logic [3:0]  ref_ram
);

   pattern_t   pattern;
   data_size_t remain;                            // Bytes left in block
   logic [7:0] byte_buf;
   logic       have_byte;
   logic       waiting;
   logic       wr_go;
   ram_addr_t  base;

   assign base    = (ref_ram == 4'd0) ? '0 : ram_addr;    // First block of a load
   assign wr_go   = fetch.busy & sdram_ready & ~ram_ce & (remain != '0) &
                    (pattern == PATTERN_RAM_INIT | have_byte);
   assign ram_din = (pattern == PATTERN_COPY) ? byte_buf :
                    (ram_addr[8] == ram_addr[1]) ? 8'h00 : 8'hFF;

   always_ff @(posedge clk) begin
      if (fetch.start) begin
         lookup_ram[ref_ram] <= '{addr: base, size: 16'(rec.size_blocks),
                                  ro: (rec.data_id != ROM_RAM)};
      end
      if (fetch.byte_ok) byte_buf <= fetch.byte_data;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fetch.busy     <= 1'b0;
         fetch.done     <= 1'b0;
         fetch.byte_req <= 1'b0;
         ram_ce         <= 1'b0;
         ram_addr       <= '0;
         remain         <= '0;
         pattern        <= PATTERN_COPY;
         have_byte      <= 1'b0;
         waiting        <= 1'b0;
      end else begin
         fetch.done     <= 1'b0;
         fetch.byte_req <= 1'b0;
         ram_ce         <= 1'b0;
         if (ram_ce) ram_addr <= ram_addr + 1'b1;
         if (fetch.start) begin
            fetch.busy <= 1'b1;
            ram_addr   <= base;
            remain     <= data_size_t'(rec.size_blocks) << BLOCK_SHIFT;
            pattern    <= (rec.data_id == ROM_RAM) ? PATTERN_RAM_INIT : PATTERN_COPY;
            have_byte  <= 1'b0;
            waiting    <= 1'b0;
         end else if (fetch.busy) begin
            if (remain == '0) begin
               fetch.busy <= 1'b0;                  // Last write is out
               fetch.done <= 1'b1;
            end else if (wr_go) begin
               ram_ce    <= 1'b1;
               remain    <= remain - 1'b1;
               have_byte <= 1'b0;
            end else if (pattern == PATTERN_COPY && !have_byte && !waiting) begin
               fetch.byte_req <= 1'b1;
               waiting        <= 1'b1;
            end
            if (fetch.byte_ok) begin
               have_byte <= 1'b1;
               waiting   <= 1'b0;
            end
         end
      end
   end

   a_ce_single: assert property (@(posedge clk) disable iff (!rst_n) ram_ce |=> !ram_ce);

endmodule

`default_nettype wire

//--- design/slot_layout_store.sv
`timescale 1ns/1ps
`default_nettype none

module slot_layout_store import upload_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        clean_wr,
   input  logic [5:0]  clean_idx,
   input  logic        store,
   record_if.user      rec,
   input  logic [3:0]  ref_ram,
   output slot_entry_t slot_layout [64]
);

   slot_entry_t new_entry [4];

   // Next value of the four subslots of the addressed slot
   always_comb begin
      for (int k = 0; k < 4; k++) begin
         new_entry[k] = slot_layout[{rec.slot_subslot, 2'(k)}];
         case (rec.mode[2*k +: 2])
            2'd1: begin
               new_entry[k]        = slot_layout[{rec.slot_subslot, rec.param[2*k +: 2]}];
               new_entry[k].device = DEVICE_NONE;
            end
            2'd2: begin
               new_entry[k] = '{mapper: rec.mapper, device: rec.device, ref_ram: ref_ram,
                                offset_ram: rec.param[2*k +: 2]};
            end
            2'd3: begin
               new_entry[k] = '{mapper: MAPPER_UNUSED, device: rec.device, ref_ram: ref_ram,
                                offset_ram: rec.param[2*k +: 2]};
            end
            default: ;                              // Keep entry
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 64; i++) begin
            slot_layout[i] <= '{mapper: MAPPER_UNUSED, device: DEVICE_NONE, ref_ram: 4'd0,
                                offset_ram: 2'd0};
         end
      end else if (clean_wr) begin
         slot_layout[clean_idx].mapper <= MAPPER_UNUSED;
         slot_layout[clean_idx].device <= DEVICE_NONE;
      end else if (store) begin
         for (int k = 0; k < 4; k++) begin
            slot_layout[{rec.slot_subslot, 2'(k)}] <= new_entry[k];
         end
      end
   end

endmodule

`default_nettype wire

//--- design/memory_upload_top.sv
`timescale 1ns/1ps
`default_nettype none

module memory_upload_top import upload_pkg::*; #(
   parameter int BLOCK_SHIFT = 14
) (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        ioctl_download,
   input  logic [15:0] ioctl_index,
   input  logic [26:0] ioctl_addr,
   output ddr_addr_t   ddr3_addr,
   output logic        ddr3_rd,
   input  logic [7:0]  ddr3_dout,
   input  logic        ddr3_ready,
   output logic        ddr3_request,
   output ram_addr_t   ram_addr,
   output logic [7:0]  ram_din,
   output logic        ram_ce,
   input  logic        sdram_ready,
   output logic        reset_rq,
   output slot_entry_t slot_layout [64],
   output lookup_ram_t lookup_ram [16]
);

   record_if   rec ();
   fetch_if    fetch ();
   logic       hdr_byte_ok;
   logic [7:0] hdr_byte;
   logic       clean_wr;
   logic [5:0] clean_idx;
   logic       store;
   logic [3:0] ref_ram;

   upload_sequencer #(.BLOCK_SHIFT(BLOCK_SHIFT)) u_seq (
      .clk, .rst_n, .ioctl_download, .ioctl_index, .ioctl_addr, .ddr3_dout, .ddr3_ready,
      .ddr3_addr, .ddr3_rd, .ddr3_request, .reset_rq, .rec, .fetch, .hdr_byte_ok,
      .hdr_byte, .clean_wr, .clean_idx, .store, .ref_ram
   );

   config_parser u_parser (.clk, .rst_n, .hdr_byte_ok, .hdr_byte, .rec);

   ram_loader #(.BLOCK_SHIFT(BLOCK_SHIFT)) u_loader (
      .clk, .rst_n, .sdram_ready, .ram_addr, .ram_din, .ram_ce, .lookup_ram,
      .rec, .fetch, .ref_ram
   );

   slot_layout_store u_slots (
      .clk, .rst_n, .clean_wr, .clean_idx, .store, .rec, .ref_ram, .slot_layout
   );

endmodule

`default_nettype wire

//--- dv/memory_upload_tb.sv
`timescale 1ns/1ps
`default_nettype none

module memory_upload_tb import upload_pkg::*; ();

   localparam int BLOCK_SHIFT = 6;
   localparam int BLOCK       = 1 << BLOCK_SHIFT;

   logic        clk;
   logic        rst_n;
   logic        ioctl_download;
   logic [15:0] ioctl_index;
   logic [26:0] ioctl_addr;
   ddr_addr_t   ddr3_addr;
   logic        ddr3_rd;
   logic [7:0]  ddr3_dout;
   logic        ddr3_ready;
   logic        ddr3_request;
   ram_addr_t   ram_addr;
   logic [7:0]  ram_din;
   logic        ram_ce;
   logic        sdram_ready;
   logic        reset_rq;
   slot_entry_t slot_layout [64];
   lookup_ram_t lookup_ram [16];

   integer      seed = 97;
   logic [7:0]  img [4096];                       // DDR3 contents
   logic [7:0]  ram [2048];
   int          img_len;
   slot_entry_t exp_slot [64];
   int          n_loaded;
   int          ld_addr [16];
   int          ld_size [16];
   logic        ld_ro [16];
   int          ld_src [16];                      // DDR3 offset of a ROM body

   memory_upload_top #(.BLOCK_SHIFT(BLOCK_SHIFT)) dut0 (
      .clk, .rst_n, .ioctl_download, .ioctl_index, .ioctl_addr, .ddr3_addr, .ddr3_rd,
      .ddr3_dout, .ddr3_ready, .ddr3_request, .ram_addr, .ram_din, .ram_ce, .sdram_ready,
      .reset_rq, .slot_layout, .lookup_ram
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp));
      end
   endtask

   function automatic int rand_below(input int n);
      return ($random(seed) & 32'h7fff_ffff) % n;
   endfunction

   task automatic put_header(input int at, input config_typ_t typ, input int slot,
                             input data_id_t id, input int blocks, input device_t dev,
                             input mapper_t map, input logic [7:0] mode,
                             input logic [7:0] param, input bit good);
      logic [10:0] sz;
      sz = 11'(blocks);
      img[at]      = good ? 8'h4D : 8'h4E;        // "M" or a broken magic
      img[at + 1]  = 8'h53;
      img[at + 2]  = 8'h58;
      img[at + 3]  = {4'(typ), 4'(slot)};
      img[at + 4]  = id;
      img[at + 5]  = {5'd0, sz[10:8]};
      img[at + 6]  = sz[7:0];
      img[at + 7]  = dev;
      img[at + 8]  = map;
      img[at + 9]  = mode;
      img[at + 10] = param;
   endtask

   // Reference for the four subslots of one record
   task automatic model_store(input int slot, input mapper_t map, input device_t dev,
                              input logic [7:0] mode, input logic [7:0] param,
                              input int ref_idx);
      slot_entry_t old [4];
      slot_entry_t e;
      logic [1:0]  m;
      logic [1:0]  p;
      for (int k = 0; k < 4; k++) old[k] = exp_slot[slot * 4 + k];
      for (int k = 0; k < 4; k++) begin
         m = mode[2 * k +: 2];
         p = param[2 * k +: 2];
         e = old[k];
         if (m == 2'd1) begin
            e = old[p];                           // Copy from the pre-store value
            e.device = DEVICE_NONE;
         end else if (m != 2'd0) begin
            e.mapper     = (m == 2'd2) ? map : MAPPER_UNUSED;
            e.device     = dev;
            e.ref_ram    = 4'(ref_idx);
            e.offset_ram = p;
         end
         exp_slot[slot * 4 + k] = e;
      end
   endtask

   task automatic build_image();
      int         at;
      int         n_rec;
      int         kind;
      int         slot;
      int         blocks;
      logic [7:0] mode;
      logic [7:0] param;
      mapper_t    map;
      device_t    dev;
      data_id_t   id;
      int         ram_ptr;
      at       = 0;
      ram_ptr  = 0;
      n_loaded = 0;
      for (int i = 0; i < 4096; i++) img[i] = $random(seed);
      for (int i = 0; i < 64; i++) begin
         exp_slot[i].mapper = MAPPER_UNUSED;      // Clean step keeps ref_ram and offset
         exp_slot[i].device = DEVICE_NONE;
      end
      n_rec = 3 + rand_below(4);
      for (int r = 0; r < n_rec; r++) begin
         kind   = (r < 3) ? r : rand_below(5);    // ROM, KBD, RAM, none, other type
         slot   = rand_below(16);
         blocks = 1 + rand_below(3);
         mode   = $random(seed);
         param  = $random(seed);
         map    = mapper_t'(rand_below(7));
         dev    = device_t'(rand_below(3));
         if (kind == 1) begin
            put_header(at, CONFIG_KBD_LAYOUT, slot, ROM_NONE, blocks, dev, map, mode, param, 1);
            at += HDR_BYTES + KBD_SKIP;
         end else if (kind == 4) begin
            put_header(at, CONFIG_CONFIG, slot, ROM_ROM, blocks, dev, map, mode, param, 1);
            at += HDR_BYTES;
         end else begin
            id = (kind == 2) ? ROM_RAM : (kind == 3) ? ROM_NONE :
                 (rand_below(2) == 0) ? ROM_ROM : ROM_FMPAC;
            put_header(at, CONFIG_SLOT_INTERNAL, slot, id, blocks, dev, map, mode, param, 1);
            at += HDR_BYTES;
            model_store(slot, map, dev, mode, param, n_loaded);
            if (kind != 3) begin
               ld_addr[n_loaded] = ram_ptr;
               ld_size[n_loaded] = blocks;
               ld_ro[n_loaded]   = (kind == 0);
               ld_src[n_loaded]  = at;
               ram_ptr += blocks * BLOCK;
               n_loaded++;
               if (kind == 0) at += blocks * BLOCK;
            end
         end
      end
      // Broken header, then a record that must never be applied
      put_header(at, CONFIG_SLOT_INTERNAL, 5, ROM_NONE, 1, DEVICE_FDC, MAPPER_NONE,
                 8'hFF, 8'h1B, 0);
      at += HDR_BYTES;
      put_header(at, CONFIG_SLOT_INTERNAL, 9, ROM_NONE, 1, DEVICE_OPL3, MAPPER_RAM,
                 8'hAA, 8'hE4, 1);
      img_len = at + HDR_BYTES;
   endtask

   // One download end, the load it starts, and the checks on its results
   task automatic run_load();
      int         cycles;
      int         a;
      logic [7:0] exp_byte;
      @(posedge clk);
      #2;
      ioctl_index    = 16'd1;
      ioctl_addr     = 27'(img_len);
      ioctl_download = 1'b1;
      @(posedge clk);
      #2;
      ioctl_download = 1'b0;                      // Download ends here

      cycles = 0;
      while (reset_rq !== 1'b1) begin
         @(posedge clk);
         #2;
         cycles++;
         if (cycles > 4) fail_run("reset_rq did not rise after the download ended");
      end
      check_value("ddr3_request", ddr3_request, 1);
      cycles = 0;
      while (reset_rq !== 1'b0) begin
         @(posedge clk);
         #2;
         cycles++;
         if (cycles > 100000) fail_run("The load did not finish, reset_rq stayed high");
      end
      check_value("ddr3_request", ddr3_request, 0);

      for (int i = 0; i < n_loaded; i++) begin
         check_value($sformatf("lookup_ram[%0d].addr", i), lookup_ram[i].addr, ld_addr[i]);
         check_value($sformatf("lookup_ram[%0d].size", i), lookup_ram[i].size, ld_size[i]);
         check_value($sformatf("lookup_ram[%0d].ro", i), lookup_ram[i].ro, ld_ro[i]);
         for (int b = 0; b < ld_size[i] * BLOCK; b++) begin
            a = ld_addr[i] + b;
            if (ld_ro[i]) exp_byte = img[ld_src[i] + b];
            else exp_byte = (a[8] == a[1]) ? 8'h00 : 8'hFF;   // Power-on pattern
            check_value($sformatf("ram[%0h]", a), ram[a], exp_byte);
         end
      end
      for (int i = 0; i < 64; i++) begin
         check_value($sformatf("slot_layout[%0d]", i), slot_layout[i], exp_slot[i]);
      end
   endtask

   // DDR3 and SDRAM models, sampled mid-cycle and updated after the edge
   initial begin
      logic      rd_hit;
      ddr_addr_t rd_addr;
      ddr3_ready  = 1'b0;
      ddr3_dout   = 8'h00;
      sdram_ready = 1'b0;
      forever begin
         @(negedge clk);
         rd_hit  = ddr3_rd & ddr3_ready;
         rd_addr = ddr3_addr;
         if (ram_ce) ram[ram_addr[10:0]] = ram_din;
         @(posedge clk);
         #2;
         if (rd_hit) ddr3_dout = img[rd_addr[11:0]];
         ddr3_ready  = ($random(seed) & 3) != 0;
         sdram_ready = ($random(seed) & 3) != 0;
      end
   end

   initial begin
      rst_n          = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index    = 16'd0;
      ioctl_addr     = '0;
      for (int i = 0; i < 64; i++) exp_slot[i] = '0;   // Slot layout after reset
      repeat (2) @(posedge clk);
      #2;
      rst_n = 1'b1;
      check_value("reset_rq", reset_rq, 0);
      check_value("ddr3_rd", ddr3_rd, 0);
      check_value("ddr3_request", ddr3_request, 0);
      check_value("ram_ce", ram_ce, 0);

      // Second load must clean the first one's slots and restart RAM at 0
      for (int n = 0; n < 2; n++) begin
         build_image();
         run_load();
      end

      $display("Finished with no errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
design/upload_pkg.sv
design/upload_if.sv
design/upload_sequencer.sv
design/config_parser.sv
design/ram_loader.sv
design/slot_layout_store.sv
design/memory_upload_top.sv
dv/memory_upload_tb.sv
